/* files.f */
hw/busPkg.sv
hw/coherencePkg.sv
hw/ramArbiter.sv
hw/instrFetch.sv
hw/coherenceEngine.sv
hw/busCtrl.sv
dv/busCtrl_chk.sv
dv/busCtrlTb.sv

/* Bender.yml */
package:
  name: busCtrl

sources:
  - hw/busPkg.sv
  - hw/coherencePkg.sv
  - hw/ramArbiter.sv
  - hw/instrFetch.sv
  - hw/coherenceEngine.sv
  - hw/busCtrl.sv
  - target: test
    files:
      - dv/busCtrl_chk.sv
      - dv/busCtrlTb.sv

/* dv/busCtrlTb.sv */
`timescale 1ns/1ps

module busCtrlTb
    import busPkg::*;
();

    localparam int TIMEOUT = 200;

    logic     CLK;
    logic     nRST;
    logic     iREN [2];
    addrT     iaddr [2];
    logic     iwait [2];
    wordT     iload [2];
    logic     dREN [2];
    logic     dWEN [2];
    addrT     daddr [2];
    wordT     dstore [2];
    logic     dwait [2];
    wordT     dload [2];
    logic     cctrans [2];
    logic     ccwrite [2];
    logic     ccwait [2];
    logic     ccinv [2];
    addrT     ccsnoopaddr [2];
    logic     ramREN;
    logic     ramWEN;
    addrT     ramaddr;
    wordT     ramstore;
    wordT     ramload;
    ramStateT ramState;

    wordT mem [256];
    int   seed = 61;
    int   lat = -1;
    int   errCount = 0;
    int   chkFails = 0;
    int   testsRun = 0;
    int   testsFailed = 0;
    int   failBase;
    // what the bus did during the running test
    int   wrCount;
    int   rdCount;
    int   wrAtFirstRd;
    int   invCount [2];
    bit   invOnLast [2];
    bit   waitSeen [2];
    addrT firstSnoop [2];
    // snooped cache holds its block modified when dirtyCfg is set
    bit   dirtyCfg [2];
    wordT peerData [2][2];
    // ccwait as seen in the previous cycle
    bit   snoopHeld [2];

    busCtrl busCtrl_i (.*);

    bind busCtrl busCtrl_chk chk_i (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // initial RAM word built from every address bit
    function automatic wordT fill(input addrT a);
        return {a[15:0], a[31:16]} ^ 32'hA5A5_5A5A;
    endfunction

    function automatic wordT memAt(input addrT a);
        return mem[a[9:2]];
    endfunction

    // RAM model and bus monitor sampled mid-cycle
    always @(negedge CLK) begin
        logic req;
        addrT a;
        if (ramState == ACCESS && ramWEN) begin
            wrCount++;
            mem[ramaddr[9:2]] = ramstore;
        end
        if (ramState == ACCESS && ramREN) begin
            if (rdCount == 0) begin
                wrAtFirstRd = wrCount;
            end
            rdCount++;
        end
        for (int c = 0; c < 2; c++) begin
            if (ccwait[c] && !waitSeen[c]) begin
                waitSeen[c] = 1'b1;
                firstSnoop[c] = ccsnoopaddr[c];
            end
            if (ccinv[c]) begin
                invCount[c]++;
                // requester finishing its last block word
                invOnLast[c] = !dwait[1 - c] && rdCount == BLOCK_WORDS;
            end
        end
        req = (ramREN || ramWEN) && ramState != ACCESS;
        a = ramaddr;
        @(posedge CLK);
        #1;
        if (!req) begin
            ramState = FREE;
            lat = -1;
        end else begin
            // ACCESS comes 1 to 4 cycles after the request
            if (lat < 0) begin
                lat = $unsigned($random(seed)) % 4;
            end
            if (lat == 0) begin
                ramState = ACCESS;
                ramload = mem[a[9:2]];
            end else begin
                ramState = BUSY;
            end
            lat--;
        end
    end

    // snooped cache answers the cycle after ccwait rises
    always @(posedge CLK) begin
        #1;
        for (int c = 0; c < 2; c++) begin
            ccwrite[c] = ccwait[c] && snoopHeld[c] && dirtyCfg[c];
            if (ccwrite[c]) begin
                daddr[c] = ccsnoopaddr[c];
                dstore[c] = peerData[c][ccsnoopaddr[c][WORD_SEL_BIT]];
            end
            snoopHeld[c] = ccwait[c];
        end
    end

    task automatic abortRun(input string why);
        $display("%s at %0t ns", why, $time);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic expectEq(input string name, input wordT got, input wordT exp);
        assert (got === exp)
        else begin
            $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic expectTrue(input string what, input bit ok);
        assert (ok)
        else begin
            $display("check failed at %0t ns: %s", $time, what);
            errCount++;
        end
    endtask

    task automatic startTest();
        failBase = errCount + chkFails;
        wrCount = 0;
        rdCount = 0;
        wrAtFirstRd = -1;
        for (int c = 0; c < 2; c++) begin
            invCount[c] = 0;
            invOnLast[c] = 1'b0;
            waitSeen[c] = 1'b0;
            firstSnoop[c] = '0;
        end
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errCount + chkFails == failBase) begin
            $display("%-16s ok", name);
        end else begin
            testsFailed++;
            $display("%-16s failed", name);
        end
    endtask

    // one two-word cache transaction with the word bit flipped between words
    task automatic dataReq(input int c, input bit wr, input bit ev, input addrT a,
                           input wordT s0, input wordT s1, output wordT l0, output wordT l1);
        wordT got [2];
        int   t;
        daddr[c] = a;
        dstore[c] = s0;
        dREN[c] = !wr;
        dWEN[c] = wr;
        cctrans[c] = ev;
        for (int w = 0; w < 2; w++) begin
            t = 0;
            do begin
                @(negedge CLK);
                t++;
            end while (dwait[c] && t < TIMEOUT);
            if (dwait[c]) begin
                abortRun($sformatf("core %0d data word %0d never completed", c, w));
            end
            got[w] = dload[c];
            @(posedge CLK);
            #1;
            daddr[c] = a ^ (addrT'(1) << WORD_SEL_BIT);
            dstore[c] = s1;
        end
        dREN[c] = 1'b0;
        dWEN[c] = 1'b0;
        cctrans[c] = 1'b0;
        l0 = got[0];
        l1 = got[1];
    endtask

    task automatic fetch(input int c, input addrT a, output wordT got);
        int t;
        iaddr[c] = a;
        iREN[c] = 1'b1;
        t = 0;
        do begin
            @(negedge CLK);
            t++;
        end while (iwait[c] && t < TIMEOUT);
        if (iwait[c]) begin
            abortRun($sformatf("core %0d instruction fetch never completed", c));
        end
        got = iload[c];
        @(posedge CLK);
        #1;
        iREN[c] = 1'b0;
    endtask

    initial begin
        wordT l0;
        wordT l1;
        wordT f0;
        time  dataT;
        time  fetT;
        nRST = 1'b0;
        ramState = FREE;
        ramload = '0;
        for (int c = 0; c < 2; c++) begin
            iREN[c] = 1'b0;
            iaddr[c] = '0;
            dREN[c] = 1'b0;
            dWEN[c] = 1'b0;
            daddr[c] = '0;
            dstore[c] = '0;
            cctrans[c] = 1'b0;
            ccwrite[c] = 1'b0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill(addrT'(i) << 2);
        end
        repeat (16) @(posedge CLK);
        #1;
        nRST = 1'b1;
        repeat (2) @(posedge CLK);
        #1;

        startTest();
        fetch(0, 32'h40, f0);
        expectEq("iload[0]", f0, fill(32'h40));
        fetch(1, 32'h44, f0);
        expectEq("iload[1]", f0, fill(32'h44));
        endTest("fetch");

        startTest();
        dataReq(0, 1'b0, 1'b0, 32'h80, '0, '0, l0, l1);
        expectTrue("ccwait[1] never rose during the snoop", waitSeen[1]);
        expectEq("ccsnoopaddr[1]", firstSnoop[1], 32'h80);
        expectEq("dload[0] word 0", l0, fill(32'h80));
        expectEq("dload[0] word 1", l1, fill(32'h84));
        expectEq("RAM writes", wrCount, 0);
        endTest("clean read miss");

        startTest();
        dirtyCfg[0] = 1'b1;
        peerData[0][0] = 32'hD1D1_00C0;
        peerData[0][1] = 32'hD1D1_00C4;
        dataReq(1, 1'b0, 1'b0, 32'hC0, '0, '0, l0, l1);
        dirtyCfg[0] = 1'b0;
        expectEq("RAM writes before first read", wrAtFirstRd, 2);
        expectEq("RAM word 0xC0", memAt(32'hC0), peerData[0][0]);
        expectEq("RAM word 0xC4", memAt(32'hC4), peerData[0][1]);
        expectEq("dload[1] word 0", l0, peerData[0][0]);
        expectEq("dload[1] word 1", l1, peerData[0][1]);
        endTest("dirty peer");

        startTest();
        dataReq(0, 1'b1, 1'b0, 32'h100, '0, '0, l0, l1);
        expectTrue("ccwait[1] never rose during the snoop", waitSeen[1]);
        expectEq("dload[0] word 0", l0, fill(32'h100));
        expectEq("dload[0] word 1", l1, fill(32'h104));
        expectEq("ccinv[1] pulses", invCount[1], 1);
        expectTrue("ccinv[1] was not on the last word", invOnLast[1]);
        expectEq("RAM writes", wrCount, 0);
        endTest("write miss");

        startTest();
        dataReq(1, 1'b1, 1'b1, 32'h140, 32'hE0E0_0140, 32'hE0E0_0144, l0, l1);
        expectEq("RAM word 0x140", memAt(32'h140), 32'hE0E0_0140);
        expectEq("RAM word 0x144", memAt(32'h144), 32'hE0E0_0144);
        expectEq("RAM writes", wrCount, 2);
        expectTrue("ccwait[0] rose during an eviction", !waitSeen[0]);
        endTest("eviction");

        startTest();
        fork
            begin
                dataReq(1, 1'b0, 1'b0, 32'h180, '0, '0, l0, l1);
                dataT = $time;
            end
            begin
                fetch(0, 32'h1C0, f0);
                fetT = $time;
            end
        join
        expectTrue("fetch finished before the data transaction", dataT < fetT);
        expectEq("dload[1] word 0", l0, fill(32'h180));
        expectEq("dload[1] word 1", l1, fill(32'h184));
        expectEq("iload[0]", f0, fill(32'h1C0));
        endTest("priority");

        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 testsRun, testsFailed, errCount, chkFails);
        if (testsFailed == 0 && errCount == 0 && chkFails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* dv/busCtrl_chk.sv */
`timescale 1ns/1ps

module busCtrl_chk
    import busPkg::*;
(
    input logic     CLK,
    input logic     nRST,
    input logic     ramREN,
    input logic     ramWEN,
    input addrT     ramaddr,
    input ramStateT ramState,
    input logic     ccwait [2],
    input logic     ccinv [2]
);

    // the RAM never sees a read and a write together
    noReadWrite: assert property (@(posedge CLK) disable iff (!nRST) !(ramREN && ramWEN))
    else begin
        $error("ramREN and ramWEN high in the same cycle");
        busCtrlTb.chkFails++;
    end

    // only one cache is snooped at a time
    oneSnoop: assert property (@(posedge CLK) disable iff (!nRST) !(ccwait[0] && ccwait[1]))
    else begin
        $error("ccwait high on both cores");
        busCtrlTb.chkFails++;
    end

    // bus is quiet when reset lifts
    quietAfterReset: assert property (@(posedge CLK) $rose(nRST) |->
        !ramREN && !ramWEN && !ccwait[0] && !ccwait[1] && !ccinv[0] && !ccinv[1])
    else begin
        $error("control output high after reset");
        busCtrlTb.chkFails++;
    end

    // request and address held until the ACCESS cycle
    holdAddr: assert property (@(posedge CLK) disable iff (!nRST)
        (ramREN || ramWEN) && ramState != ACCESS |=> (ramREN || ramWEN) && $stable(ramaddr))
    else begin
        $error("RAM request dropped or address moved before ACCESS");
        busCtrlTb.chkFails++;
    end

    invPulse: assert property (@(posedge CLK) disable iff (!nRST)
        (ccinv[0] || ccinv[1]) |=> !(ccinv[0] || ccinv[1]))
    else begin
        $error("ccinv high for more than one cycle");
        busCtrlTb.chkFails++;
    end

endmodule

/* hw/busCtrl.sv */
`timescale 1ns/1ps

module busCtrl
    import busPkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     iREN [2],
    input  addrT     iaddr [2],
    output logic     iwait [2],
    output wordT     iload [2],
    input  logic     dREN [2],
    input  logic     dWEN [2],
    input  addrT     daddr [2],
    input  wordT     dstore [2],
    output logic     dwait [2],
    output wordT     dload [2],
    input  logic     cctrans [2],
    input  logic     ccwrite [2],
    output logic     ccwait [2],
    output logic     ccinv [2],
    output addrT     ccsnoopaddr [2],
    output logic     ramREN,
    output logic     ramWEN,
    output addrT     ramaddr,
    output wordT     ramstore,
    input  wordT     ramload,
    input  ramStateT ramState
);

    // engine to arbiter
    logic engReq;
    logic engWrite;
    logic engLast;
    logic engBusy;
    logic engDone;
    addrT engAddr;
    wordT engStore;

    // fetch to arbiter
    logic fetReq;
    logic fetLast;
    logic fetDone;
    addrT fetAddr;

    ramArbiter ramArbiter_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .engReq   (engReq),
        .engWrite (engWrite),
        .engLast  (engLast),
        .engBusy  (engBusy),
        .engAddr  (engAddr),
        .engStore (engStore),
        .engDone  (engDone),
        .fetReq   (fetReq),
        .fetLast  (fetLast),
        .fetAddr  (fetAddr),
        .fetDone  (fetDone),
        .ramREN   (ramREN),
        .ramWEN   (ramWEN),
        .ramaddr  (ramaddr),
        .ramstore (ramstore),
        .ramState (ramState)
    );

    instrFetch instrFetch_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .iREN    (iREN),
        .iaddr   (iaddr),
        .iwait   (iwait),
        .iload   (iload),
        .fetReq  (fetReq),
        .fetLast (fetLast),
        .fetAddr (fetAddr),
        .fetDone (fetDone),
        .ramload (ramload)
    );

    coherenceEngine coherenceEngine_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .dREN        (dREN),
        .dWEN        (dWEN),
        .cctrans     (cctrans),
        .ccwrite     (ccwrite),
        .daddr       (daddr),
        .dstore      (dstore),
        .dwait       (dwait),
        .ccwait      (ccwait),
        .ccinv       (ccinv),
        .dload       (dload),
        .ccsnoopaddr (ccsnoopaddr),
        .engReq      (engReq),
        .engWrite    (engWrite),
        .engLast     (engLast),
        .engBusy     (engBusy),
        .engAddr     (engAddr),
        .engStore    (engStore),
        .engDone     (engDone),
        .ramload     (ramload)
    );

endmodule

/* hw/coherenceEngine.sv */
`timescale 1ns/1ps

module coherenceEngine
    import busPkg::*, coherencePkg::*;
(
    input  logic CLK,
    input  logic nRST,
    input  logic dREN [2],
    input  logic dWEN [2],
    input  logic cctrans [2],
    input  logic ccwrite [2],
    input  addrT daddr [2],
    input  wordT dstore [2],
    output logic dwait [2],
    output logic ccwait [2],
    output logic ccinv [2],
    output wordT dload [2],
    output addrT ccsnoopaddr [2],
    output logic engReq,
    output logic engWrite,
    output logic engLast,
    output logic engBusy,
    output addrT engAddr,
    output wordT engStore,
    input  logic engDone,
    input  wordT ramload
);

    cohStateT state;
    cohStateT nextState;
    coreT     req;
    coreT     peer;
    coreT     pick;
    logic     isWrite;
    logic     peerDirty;
    logic     [$clog2(BLOCK_WORDS)-1:0] wordCnt;
    logic     lastWord;
    logic     anyReq;
    logic     evict;
    logic     snooping;
    logic     dataWordDone;
    addrT     secondAddr;
    addrT     snoopAddr;

    assign peer = ~req;

    // block size is a power of two
    assign lastWord = &wordCnt;

    // data before instructions, core 0 before core 1
    assign anyReq = dREN[0] | dWEN[0] | dREN[1] | dWEN[1];
    assign pick   = coreT'(~(dREN[0] | dWEN[0]));
    assign evict  = dWEN[pick] & cctrans[pick];

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (anyReq) begin
                    nextState = evict ? EVICT : SNOOP;
                end
            end
            SNOOP: nextState = DECIDE;
            // peer answers one cycle after ccwait rises
            DECIDE: nextState = ccwrite[peer] ? PEERWB : READ;
            PEERWB: begin
                if (engDone && lastWord) begin
                    nextState = READ;
                end
            end
            READ, EVICT: begin
                if (engDone && lastWord) begin
                    nextState = IDLE;
                end
            end
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            req       <= '0;
            isWrite   <= 1'b0;
            peerDirty <= 1'b0;
            wordCnt   <= '0;
        end else begin
            state <= nextState;
            case (state)
                IDLE: begin
                    if (anyReq) begin
                        req       <= pick;
                        isWrite   <= dWEN[pick];
                        peerDirty <= 1'b0;
                        wordCnt   <= '0;
                    end
                end
                DECIDE: peerDirty <= ccwrite[peer];
                PEERWB, READ, EVICT: begin
                    // wraps to zero after the last word
                    if (engDone) begin
                        wordCnt <= wordCnt + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // RAM side
    assign engReq   = (state == PEERWB) | (state == READ) | (state == EVICT);
    assign engWrite = (state == PEERWB) | (state == EVICT);
    assign engLast  = ((state == READ) | (state == EVICT)) & lastWord;
    assign engAddr  = (state == PEERWB) ? daddr[peer] : daddr[req];
    assign engStore = (state == PEERWB) ? dstore[peer] : dstore[req];

    // keeps fetch off the RAM from accept through the last word
    assign engBusy = (state != IDLE) | anyReq;

    // snoop side, second peer word gets the other half of the block
    assign snooping   = (state == SNOOP) | (state == DECIDE) |
                        ((state == PEERWB) & peerDirty);
    assign secondAddr = daddr[req] ^ (addrT'(1) << WORD_SEL_BIT);
    assign snoopAddr  = ((state == PEERWB) && lastWord) ? secondAddr : daddr[req];

    assign dataWordDone = ((state == READ) | (state == EVICT)) & engDone;

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            ccwait[c]      = snooping & (peer == coreT'(c));
            ccsnoopaddr[c] = (snooping && peer == coreT'(c)) ? snoopAddr : '0;
            // write miss takes ownership, so drop the peer copy
            ccinv[c] = (peer == coreT'(c)) & isWrite & (state == READ) &
                       engDone & lastWord;
            dwait[c] = (dREN[c] | dWEN[c]) & ~(dataWordDone & (req == coreT'(c)));
            dload[c] = ramload;
        end
    end

endmodule

/* hw/instrFetch.sv */
`timescale 1ns/1ps

module instrFetch
    import busPkg::*;
(
    input  logic CLK,
    input  logic nRST,
    input  logic iREN [2],
    input  addrT iaddr [2],
    output logic iwait [2],
    output wordT iload [2],
    output logic fetReq,
    output logic fetLast,
    output addrT fetAddr,
    input  logic fetDone,
    input  wordT ramload
);

    logic busy;
    logic cur;
    logic curLatched;

    // core 0 first, then hold the choice until the word is back
    assign cur = busy ? curLatched : ~iREN[0];

    assign fetReq  = busy | iREN[0] | iREN[1];
    assign fetAddr = iaddr[cur];
    // single word fetch, so every granted word is the last
    assign fetLast = fetReq;

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            iwait[c] = iREN[c] & ~(fetDone & (cur == c[0]));
            iload[c] = ramload;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy       <= 1'b0;
            curLatched <= 1'b0;
        end else begin
            busy       <= fetReq & ~fetDone;
            curLatched <= cur;
        end
    end

endmodule

/* hw/ramArbiter.sv */
`timescale 1ns/1ps

module ramArbiter
    import busPkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     engReq,
    input  logic     engWrite,
    input  logic     engLast,
    input  logic     engBusy,
    input  addrT     engAddr,
    input  wordT     engStore,
    output logic     engDone,
    input  logic     fetReq,
    input  logic     fetLast,
    input  addrT     fetAddr,
    output logic     fetDone,
    output logic     ramREN,
    output logic     ramWEN,
    output addrT     ramaddr,
    output wordT     ramstore,
    input  ramStateT ramState
);

    logic busy;
    logic ownerEng;
    logic selEng;
    logic selReq;
    logic selLast;
    logic access;

    // between transactions a pending engine transaction beats fetch
    assign selEng = busy ? ownerEng : (engReq | engBusy);
    assign access = (ramState == ACCESS);

    assign ramREN   = selEng ? (engReq & ~engWrite) : fetReq;
    assign ramWEN   = selEng & engReq & engWrite;
    assign ramaddr  = selEng ? engAddr : fetAddr;
    // fetch never writes
    assign ramstore = engStore;

    assign engDone = selEng & engReq & access;
    assign fetDone = ~selEng & fetReq & access;

    assign selReq  = selEng ? engReq : fetReq;
    assign selLast = selEng ? engLast : fetLast;

    // grant stays with the owner until its last word completes
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy     <= 1'b0;
            ownerEng <= 1'b0;
        end else if (!busy) begin
            if (selReq && !((engDone || fetDone) && selLast)) begin
                busy     <= 1'b1;
                ownerEng <= selEng;
            end
        end else if ((engDone || fetDone) && selLast) begin
            busy <= 1'b0;
        end
    end

endmodule

/* hw/coherencePkg.sv */
package coherencePkg;

    // index of one of the two cores
    typedef logic [0:0] coreT;

    // coherence engine states
    typedef enum logic [2:0] {
        IDLE,
        SNOOP,
        DECIDE,
        PEERWB,
        READ,
        EVICT
    } cohStateT;

endpackage

/* hw/busPkg.sv */
package busPkg;

    // one RAM data word and one byte address
    typedef logic [31:0] wordT;
    typedef logic [31:0] addrT;

    // condition reported by the RAM each cycle
    typedef enum logic [1:0] {
        FREE,
        BUSY,
        ACCESS,
        ERROR
    } ramStateT;

    // block geometry
    localparam int WORD_BYTES = 4;
    localparam int BLOCK_WORDS = 2;

    // address bit that picks the word inside a block
    localparam int WORD_SEL_BIT = $clog2(WORD_BYTES);

endpackage
